//--- dds_macros.svh
//////////////////////////////
// dds front end constants
// widths, register instructions, nibble limits,
// chip init word and io-update length
//////////////////////////////
`ifndef DDS_MACROS_SVH
`define DDS_MACROS_SVH

// host side and serial bus widths
`define DDS_DATA_W 32
`define DDS_FRAME_W 40
`define DDS_NIB_W 4
`define DDS_LIMIT_W 4

// last nibble index sent per command
`define DDS_LIM_FRQ 4'd9
`define DDS_LIM_PHS 4'd5
`define DDS_LIM_AMP 4'd7
`define DDS_LIM_CHN 4'd3

// channel register instruction bytes
`define DDS_INSTR_FRQ 8'h04
`define DDS_INSTR_PHS 8'h05
`define DDS_INSTR_AMP 8'h06

// amplitude multiplier enable, sits right after the instruction
`define DDS_AMP_PREFIX 12'h001

// csr write: both channels on, 4-bit serial, msb first
`define DDS_INIT_WORD 16'h00C6

// io-update pulse length in clocks
`define DDS_IOUPD_CYC 4

// capture register for readback
`define DDS_CAP_W 64

`endif

//--- ddsPkg.sv
//////////////////////////////
// dds front end types
// command enum, frame union, mode select
//////////////////////////////
`default_nettype none

`include "dds_macros.svh"

package ddsPkg;

	// low two bits of the host command
	typedef enum logic [1:0] {
		CMD_FRQ = 2'b00,
		CMD_PHS = 2'b01,
		CMD_AMP = 2'b10,
		CMD_CHN = 2'b11
	} ddsCmd_e;

	// instruction byte plus payload, formatter view
	typedef struct packed {
		logic [`DDS_FRAME_W-`DDS_DATA_W-1:0] instr;
		logic [`DDS_DATA_W-1:0] payload;
	} ddsFrameFields_t;

	// same 40 bits, seen as ten nibbles by the serializer
	// nibble 9 goes out first
	typedef union packed {
		ddsFrameFields_t fields;
		logic [`DDS_FRAME_W/`DDS_NIB_W-1:0][`DDS_NIB_W-1:0] nibble;
	} ddsFrame_u;

	// host sel bits
	// shortForm is bit 1, initMode is bit 0
	typedef struct packed {
		logic shortForm;
		logic initMode;
	} ddsSel_t;

endpackage

`default_nettype wire

//--- ddsCmdFormat.sv
//////////////////////////////
// ddsCmdFormat
// board address match, opcode decode,
// frame and nibble-limit registers
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "dds_macros.svh"

module ddsCmdFormat import ddsPkg::*; #(
	parameter logic [1:0] myAddr = 2'd0
) (
	input wire logic clk_i,
	input wire logic rstN_i,
	input wire logic [`DDS_DATA_W-1:0] data_i,
	input wire logic [3:0] cmd_i,
	input wire logic cmdTrig_i,
	input wire ddsSel_t sel_i,
	input wire logic ready_i,
	input wire logic ddsResetReq_i,
	output ddsFrame_u frame_o,
	output logic [`DDS_LIMIT_W-1:0] limit_o,
	output logic start_o,
	output logic ddsReset_o
);

	// top bits of the command pick the board
	logic addrHit;
	logic accept;
	ddsCmd_e op;
	ddsFrame_u nextFrame;
	logic [`DDS_LIMIT_W-1:0] nextLimit;

	assign addrHit = (cmd_i[3:2] == myAddr);
	assign op = ddsCmd_e'(cmd_i[1:0]);
	// only take a word while the sequencer is idle
	assign accept = cmdTrig_i & addrHit & ready_i;

	// chip reset passes through only for our address
	assign ddsReset_o = ddsResetReq_i & addrHit;

	//////////////////////////////
	// frame formatting
	//////////////////////////////
	always_comb begin
		nextFrame = '0;
		nextLimit = `DDS_LIM_CHN;
		case (op)
			CMD_FRQ: begin
				nextLimit = `DDS_LIM_FRQ;
				nextFrame.fields.instr = `DDS_INSTR_FRQ;
				nextFrame.fields.payload = data_i;
			end
			CMD_PHS: begin
				nextLimit = `DDS_LIM_PHS;
				if (sel_i.shortForm) begin
					nextFrame.fields.instr = `DDS_INSTR_PHS;
					nextFrame.fields.payload = {2'b00, data_i[13:0], 16'h0000};
				end else begin
					// host supplies instruction and word, 24 bits
					nextFrame.fields.instr = data_i[23:16];
					nextFrame.fields.payload = {data_i[15:0], 16'h0000};
				end
			end
			CMD_AMP: begin
				nextLimit = `DDS_LIM_AMP;
				if (sel_i.shortForm) begin
					nextFrame.fields.instr = `DDS_INSTR_AMP;
					nextFrame.fields.payload = {`DDS_AMP_PREFIX, 2'b00, data_i[9:0], 8'h00};
				end else begin
					nextFrame.fields.instr = data_i[31:24];
					nextFrame.fields.payload = {data_i[23:0], 8'h00};
				end
			end
			default: begin
				// channel select, 16 bits only
				nextLimit = `DDS_LIM_CHN;
				nextFrame.fields.instr = data_i[15:8];
				nextFrame.fields.payload = {data_i[7:0], 24'h000000};
			end
		endcase
	end

	// payload regs, loaded on accept
	always_ff @(posedge clk_i) begin
		if (accept) begin
			frame_o <= nextFrame;
			limit_o <= nextLimit;
		end
	end

	// one-cycle kick to the sequencer
	always_ff @(posedge clk_i) begin
		if (!rstN_i) begin
			start_o <= 1'b0;
		end else begin
			start_o <= accept;
		end
	end

	// ready must drop right after a kick, so no back-to-back starts
	assert property (@(posedge clk_i) disable iff (!rstN_i) start_o |=> !start_o);

endmodule

`default_nettype wire

//--- ddsShiftOut.sv
//////////////////////////////
// ddsShiftOut
// nibble counter for 4-wire frames,
// bit counter for the 1-wire init word
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "dds_macros.svh"

module ddsShiftOut import ddsPkg::*; (
	input wire logic clk_i,
	input wire logic rstN_i,
	input wire ddsFrame_u frame_i,
	input wire logic [`DDS_LIMIT_W-1:0] limit_i,
	input wire ddsSel_t sel_i,
	input wire logic sending_i,
	output logic [`DDS_NIB_W-1:0] sdio_o,
	output logic lastNibble_o,
	output logic shiftEn_o
);

	// index of the first nibble on the wire
	localparam logic [`DDS_LIMIT_W-1:0] nibTop = `DDS_LIMIT_W'(`DDS_FRAME_W / `DDS_NIB_W - 1);
	localparam logic [15:0] initWord = `DDS_INIT_WORD;

	logic [`DDS_LIMIT_W-1:0] nibCnt;
	logic [3:0] bitCnt;
	logic quadLast;
	logic initLast;

	//////////////////////////////
	// counters
	//////////////////////////////

	// quad mode, counts nibbles sent so far
	always_ff @(posedge clk_i) begin
		if (!rstN_i) begin
			nibCnt <= '0;
		end else if (sending_i && !sel_i.initMode) begin
			nibCnt <= nibCnt + 1'b1;
		end else begin
			nibCnt <= '0;
		end
	end

	// init mode, sixteen bits then wraps back to zero
	always_ff @(posedge clk_i) begin
		if (!rstN_i) begin
			bitCnt <= '0;
		end else if (sending_i && sel_i.initMode) begin
			bitCnt <= bitCnt + 1'b1;
		end else begin
			bitCnt <= '0;
		end
	end

	// end of frame per mode
	assign quadLast = (nibCnt == limit_i);
	assign initLast = &bitCnt;

	assign lastNibble_o = sending_i & (sel_i.initMode ? initLast : quadLast);

	//////////////////////////////
	// data select
	//////////////////////////////
	always_comb begin
		sdio_o = '0;
		if (sending_i) begin
			if (sel_i.initMode) begin
				// single wire, upper lines held low
				sdio_o = {{(`DDS_NIB_W-1){1'b0}}, initWord[4'd15 - bitCnt]};
			end else begin
				// msb nibble first
				sdio_o = frame_i.nibble[nibTop - nibCnt];
			end
		end
	end

	// every sending cycle puts one nibble on the bus
	assign shiftEn_o = sending_i;

	// the sequencer has to end the burst at the limit
	assert property (@(posedge clk_i) disable iff (!rstN_i)
		(sending_i && !sel_i.initMode) |-> (nibCnt <= limit_i));

endmodule

`default_nettype wire

//--- ddsXferSeq.sv
//////////////////////////////
// ddsXferSeq
// idle / send / io-update sequencer,
// chip select and ready
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "dds_macros.svh"

module ddsXferSeq (
	input wire logic clk_i,
	input wire logic rstN_i,
	input wire logic start_i,
	input wire logic lastNibble_i,
	output logic sending_o,
	output logic csb_o,
	output logic ioUpdate_o,
	output logic ready_o
);

	localparam int ioW = $clog2(`DDS_IOUPD_CYC);
	localparam logic [ioW-1:0] ioLast = ioW'(`DDS_IOUPD_CYC - 1);

	// FSM encoding
	localparam logic [1:0] stIdle = 2'd0;
	localparam logic [1:0] stSend = 2'd1;
	localparam logic [1:0] stUpd = 2'd2;

	logic [1:0] state;
	logic [ioW-1:0] ioCnt;

	//////////////////////////////
	// FSM
	//////////////////////////////
	always_ff @(posedge clk_i) begin
		if (!rstN_i) begin
			state <= stIdle;
			ioCnt <= '0;
		end else begin
			case (state)
				stIdle: begin
					ioCnt <= '0;
					if (start_i) begin
						state <= stSend;
					end
				end
				stSend: begin
					// serializer flags the final nibble
					if (lastNibble_i) begin
						state <= stUpd;
					end
				end
				stUpd: begin
					ioCnt <= ioCnt + 1'b1;
					if (ioCnt == ioLast) begin
						state <= stIdle;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	assign sending_o = (state == stSend);
	// chip selected only while data moves
	assign csb_o = ~sending_o;
	assign ioUpdate_o = (state == stUpd);
	// start is in flight for one cycle, hide it from the host
	assign ready_o = (state == stIdle) & ~start_i;

	// update pulse follows the burst with chip deselected
	assert property (@(posedge clk_i) disable iff (!rstN_i)
		$fell(sending_o) |-> (ioUpdate_o && csb_o));

	// host sees ready again as soon as the update ends
	assert property (@(posedge clk_i) disable iff (!rstN_i)
		$fell(ioUpdate_o) |-> (ready_o && !sending_o));

endmodule

`default_nettype wire

//--- spiCapture.sv
//////////////////////////////
// spiCapture
// 64-bit history of driven nibbles
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "dds_macros.svh"

module spiCapture (
	input wire logic clk_i,
	input wire logic rstN_i,
	input wire logic [`DDS_NIB_W-1:0] sdio_i,
	input wire logic shiftEn_i,
	output logic [`DDS_CAP_W-1:0] check_o
);

	// newest nibble lands in the low bits
	logic [`DDS_CAP_W-1:0] capReg;

	always_ff @(posedge clk_i) begin
		if (!rstN_i) begin
			capReg <= '0;
		end else if (shiftEn_i) begin
			capReg <= {capReg[`DDS_CAP_W-`DDS_NIB_W-1:0], sdio_i};
		end
	end

	// readback for the host
	assign check_o = capReg;

endmodule

`default_nettype wire

//--- ad9959Ctrl.sv
//////////////////////////////
// ad9959Ctrl
// top level of the dds command front end
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "dds_macros.svh"

module ad9959Ctrl import ddsPkg::*; #(
	parameter logic [1:0] myAddr = 2'd0
) (
	input wire logic clk_i,
	input wire logic rstN_i,
	input wire logic [`DDS_DATA_W-1:0] data_i,
	input wire logic [3:0] cmd_i,
	input wire logic cmdTrig_i,
	input wire ddsSel_t sel_i,
	input wire logic ddsResetReq_i,
	output logic [`DDS_NIB_W-1:0] sdio_o,
	output logic sclk_o,
	output logic csb_o,
	output logic ioUpdate_o,
	output logic ddsReset_o,
	output logic ready_o,
	output logic [`DDS_CAP_W-1:0] check_o
);

	ddsFrame_u frame;
	logic [`DDS_LIMIT_W-1:0] limit;
	logic start;
	logic sending;
	logic lastNibble;
	logic shiftEn;

	// chip samples sdio on the opposite edge
	assign sclk_o = ~clk_i;

	ddsCmdFormat #(
		.myAddr(myAddr)
	) cmdFormat (
		.clk_i(clk_i),
		.rstN_i(rstN_i),
		.data_i(data_i),
		.cmd_i(cmd_i),
		.cmdTrig_i(cmdTrig_i),
		.sel_i(sel_i),
		.ready_i(ready_o),
		.ddsResetReq_i(ddsResetReq_i),
		.frame_o(frame),
		.limit_o(limit),
		.start_o(start),
		.ddsReset_o(ddsReset_o)
	);

	ddsShiftOut shiftOut (
		.clk_i(clk_i),
		.rstN_i(rstN_i),
		.frame_i(frame),
		.limit_i(limit),
		.sel_i(sel_i),
		.sending_i(sending),
		.sdio_o(sdio_o),
		.lastNibble_o(lastNibble),
		.shiftEn_o(shiftEn)
	);

	ddsXferSeq xferSeq (
		.clk_i(clk_i),
		.rstN_i(rstN_i),
		.start_i(start),
		.lastNibble_i(lastNibble),
		.sending_o(sending),
		.csb_o(csb_o),
		.ioUpdate_o(ioUpdate_o),
		.ready_o(ready_o)
	);

	// readback of everything put on the bus
	spiCapture capture (
		.clk_i(clk_i),
		.rstN_i(rstN_i),
		.sdio_i(sdio_o),
		.shiftEn_i(shiftEn),
		.check_o(check_o)
	);

endmodule

`default_nettype wire

//--- tbAd9959Ctrl.sv
//////////////////////////////
// testbench for ad9959Ctrl
// file-driven commands, nibble stream model,
// compare tasks and watchdog
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "dds_macros.svh"

module tbAd9959Ctrl import ddsPkg::*; ();

	// board address strapped on the DUT
	localparam logic [1:0] boardAddr = 2'd1;
	// longest transfer is init mode, 16 bits plus 5 cycles
	localparam int quietCycles = 24;
	localparam int cyclesPerLine = 40;
	localparam int slackCycles = 200;

	logic clk_i;
	logic rstN_i;
	logic [`DDS_DATA_W-1:0] data_i;
	logic [3:0] cmd_i;
	logic cmdTrig_i;
	ddsSel_t sel_i;
	logic ddsResetReq_i;
	logic [`DDS_NIB_W-1:0] sdio_o;
	logic sclk_o;
	logic csb_o;
	logic ioUpdate_o;
	logic ddsReset_o;
	logic ready_o;
	logic [`DDS_CAP_W-1:0] check_o;

	// one entry per file line
	logic [1:0] addrQ[$];
	logic [1:0] opQ[$];
	ddsSel_t selQ[$];
	logic [`DDS_DATA_W-1:0] dataQ[$];
	logic dupQ[$];
	logic [`DDS_CAP_W-1:0] expQ[$];
	int lineCount;
	logic loaded;

	// bus monitor and reference model state
	logic [`DDS_NIB_W-1:0] gotNib[$];
	logic [`DDS_NIB_W-1:0] expNib[$];
	int ioPulses;
	logic prevIo;
	logic monitorOn;
	logic [`DDS_CAP_W-1:0] capModel;

	ad9959Ctrl #(
		.myAddr(boardAddr)
	) uut (
		.clk_i(clk_i),
		.rstN_i(rstN_i),
		.data_i(data_i),
		.cmd_i(cmd_i),
		.cmdTrig_i(cmdTrig_i),
		.sel_i(sel_i),
		.ddsResetReq_i(ddsResetReq_i),
		.sdio_o(sdio_o),
		.sclk_o(sclk_o),
		.csb_o(csb_o),
		.ioUpdate_o(ioUpdate_o),
		.ddsReset_o(ddsReset_o),
		.ready_o(ready_o),
		.check_o(check_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	//////////////////////////////
	// error path and compares
	//////////////////////////////
	task automatic failRun(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkCapture(input string name, input logic [`DDS_CAP_W-1:0] got,
		input logic [`DDS_CAP_W-1:0] exp);
		if (got !== exp) begin
			failRun($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic checkNibble(input string name, input logic [`DDS_NIB_W-1:0] got,
		input logic [`DDS_NIB_W-1:0] exp);
		if (got !== exp) begin
			failRun($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic checkFrameCount(input string name, input int got, input int exp);
		if (got != exp) begin
			failRun($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			failRun($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	//////////////////////////////
	// stimulus file and model
	//////////////////////////////
	task automatic loadCommands();
		int fd;
		int rc;
		string lineBuf;
		logic [1:0] fAddr;
		logic [1:0] fOp;
		logic [1:0] fSel;
		logic [`DDS_DATA_W-1:0] fData;
		logic fDup;
		logic [`DDS_CAP_W-1:0] fExp;
		fd = $fopen("dds_input.txt", "r");
		if (fd == 0) begin
			failRun("could not open dds_input.txt for reading");
		end else begin
			while (!$feof(fd)) begin
				rc = $fgets(lineBuf, fd);
				if (rc > 0) begin
					rc = $sscanf(lineBuf, "%h %h %h %h %h %h", fAddr, fOp, fSel, fData,
						fDup, fExp);
					// header and blank lines give fewer fields
					if (rc == 6) begin
						addrQ.push_back(fAddr);
						opQ.push_back(fOp);
						selQ.push_back(fSel);
						dataQ.push_back(fData);
						dupQ.push_back(fDup);
						expQ.push_back(fExp);
					end
				end
			end
			$fclose(fd);
			lineCount = addrQ.size();
		end
	endtask

	// expected nibbles on sdio for one accepted command
	task automatic buildExpected(input ddsCmd_e op, input ddsSel_t sel,
		input logic [`DDS_DATA_W-1:0] d);
		logic [`DDS_FRAME_W-1:0] frame;
		logic [15:0] initBits;
		int count;
		int i;
		frame = '0;
		count = 0;
		// chip control word, bit-serial on sdio[0]
		initBits = 16'h00C6;
		expNib.delete();
		if (sel.initMode) begin
			for (i = 15; i >= 0; i--) begin
				expNib.push_back({3'b000, initBits[i]});
			end
		end else begin
			case (op)
				CMD_FRQ: begin
					frame = {8'h04, d};
					count = 10;
				end
				CMD_PHS: begin
					frame = sel.shortForm ? {8'h05, 2'b00, d[13:0], 16'h0000} : {d[23:0], 16'h0000};
					count = 6;
				end
				CMD_AMP: begin
					frame = sel.shortForm ? {8'h06, 12'h001, 2'b00, d[9:0], 8'h00} : {d, 8'h00};
					count = 8;
				end
				default: begin
					frame = {d[15:0], 24'h000000};
					count = 4;
				end
			endcase
			// top nibble first
			for (i = 0; i < count; i++) begin
				expNib.push_back(frame[`DDS_FRAME_W - 1 - 4 * i -: 4]);
			end
		end
	endtask

	task automatic waitReady();
		do begin
			@(negedge clk_i);
		end while (!ready_o);
	endtask

	//////////////////////////////
	// one command, drive and compare
	//////////////////////////////
	task automatic applyCommand(input int idx);
		logic hit;
		int pulsesBefore;
		int i;
		hit = (addrQ[idx] == boardAddr);
		expNib.delete();
		if (hit) begin
			buildExpected(ddsCmd_e'(opQ[idx]), selQ[idx], dataQ[idx]);
		end
		pulsesBefore = ioPulses;
		gotNib.delete();
		@(posedge clk_i);
		cmd_i <= {addrQ[idx], opQ[idx]};
		data_i <= dataQ[idx];
		sel_i <= selQ[idx];
		cmdTrig_i <= 1'b1;
		ddsResetReq_i <= 1'b1;
		@(posedge clk_i);
		cmdTrig_i <= 1'b0;
		ddsResetReq_i <= 1'b0;
		if (hit) begin
			@(negedge clk_i);
			checkFlag("ready_o", ready_o, 1'b0);
			if (dupQ[idx]) begin
				// second trigger lands while the frame is on the bus
				// inverted data would garble sdio if it were taken
				@(posedge clk_i);
				data_i <= ~dataQ[idx];
				cmdTrig_i <= 1'b1;
				@(posedge clk_i);
				cmdTrig_i <= 1'b0;
			end
			waitReady();
		end else begin
			// wrong board, bus must stay quiet
			repeat (quietCycles) begin
				@(negedge clk_i);
				checkFlag("ready_o", ready_o, 1'b1);
				checkFlag("csb_o", csb_o, 1'b1);
			end
		end
		checkFrameCount("sdio_o nibble count", gotNib.size(), expNib.size());
		for (i = 0; i < expNib.size(); i++) begin
			checkNibble("sdio_o", gotNib[i], expNib[i]);
			capModel = {capModel[`DDS_CAP_W-`DDS_NIB_W-1:0], expNib[i]};
		end
		checkFrameCount("ioUpdate_o pulses", ioPulses - pulsesBefore, hit ? 1 : 0);
		checkCapture("capture model", capModel, expQ[idx]);
		checkCapture("check_o", check_o, capModel);
	endtask

	// sampled on the falling edge, inputs settle after the rising one
	always @(negedge clk_i) begin
		if (monitorOn) begin
			if (!csb_o) begin
				gotNib.push_back(sdio_o);
				checkFlag("ready_o", ready_o, 1'b0);
			end
			if (ioUpdate_o) begin
				checkFlag("csb_o", csb_o, 1'b1);
				if (!prevIo) begin
					ioPulses = ioPulses + 1;
				end
			end
			checkFlag("ddsReset_o", ddsReset_o, ddsResetReq_i && (cmd_i[3:2] == boardAddr));
			prevIo = ioUpdate_o;
		end
	end

	// serial clock is the inverted clock, looked at mid-phase
	always @(clk_i) begin
		#2;
		if (monitorOn) begin
			checkFlag("sclk_o", sclk_o, ~clk_i);
		end
	end

	// budget grows with the number of commands
	initial begin
		wait (loaded);
		repeat (lineCount * cyclesPerLine + slackCycles) @(posedge clk_i);
		failRun("timeout: the DUT never finished the command list");
	end

	initial begin
		int i;
		rstN_i = 1'b0;
		data_i = '0;
		cmd_i = '0;
		cmdTrig_i = 1'b0;
		sel_i = '0;
		ddsResetReq_i = 1'b0;
		loaded = 1'b0;
		monitorOn = 1'b0;
		ioPulses = 0;
		prevIo = 1'b0;
		capModel = '0;
		lineCount = 0;
		loadCommands();
		if (lineCount == 0) begin
			failRun("dds_input.txt holds no command lines");
		end
		loaded = 1'b1;
		repeat (5) @(posedge clk_i);
		rstN_i <= 1'b1;
		@(negedge clk_i);
		// idle state out of reset
		checkFlag("csb_o", csb_o, 1'b1);
		checkFlag("ioUpdate_o", ioUpdate_o, 1'b0);
		checkFlag("sending", uut.sending, 1'b0);
		checkFlag("ready_o", ready_o, 1'b1);
		checkCapture("check_o", check_o, '0);
		monitorOn = 1'b1;
		for (i = 0; i < lineCount; i++) begin
			applyCommand(i);
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- dds_input.txt
# addr op sel data dup expected_check, all hex
# op 0 frq 1 phs 2 amp 3 chn; sel bit1 short form, bit0 init; dup 1 retriggers while busy
1 0 0 12345678 0 0000000412345678
1 1 2 0000ABCD 0 0412345678052BCD
1 1 0 00A1B2C3 0 5678052BCDA1B2C3
1 2 2 DEADBEEF 1 CDA1B2C3060012EF
1 2 0 89ABCDEF 0 060012EF89ABCDEF
1 3 0 00005A3C 0 12EF89ABCDEF5A3C
0 0 0 FFFFFFFF 0 12EF89ABCDEF5A3C
1 0 1 00000000 0 0000000011000110
1 0 0 CAFEF00D 1 00011004CAFEF00D
2 3 0 00001234 0 00011004CAFEF00D
1 3 2 ABCD1234 1 1004CAFEF00D1234
1 1 2 FFFFFFFF 0 FEF00D1234053FFF
3 2 2 00000000 0 FEF00D1234053FFF
1 3 3 00000000 1 0000000011000110
1 2 0 0F1E2D3C 0 110001100F1E2D3C
1 0 0 00000000 0 1E2D3C0400000000
1 1 0 FF123456 0 0400000000123456
1 3 0 0000BEEF 0 000000123456BEEF
1 2 2 00000155 0 3456BEEF06001155
1 0 0 13579BDF 1 0011550413579BDF

//--- compile.f
+incdir+.
ddsPkg.sv
ddsCmdFormat.sv
ddsShiftOut.sv
ddsXferSeq.sv
spiCapture.sv
ad9959Ctrl.sv
tbAd9959Ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run tbAd9959Ctrl with Verilator, verdict taken from sim.log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --assert -j 0 \
	-f compile.f \
	--top-module tbAd9959Ctrl \
	-o simTb \
	&& ./obj_dir/simTb > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qsx "ALL CHECKS PASSED" sim.log \
	&& echo "simulation passed" \
	&& exit 0 \
	|| { echo "simulation failed, see sim.log"; exit 1; }
